//--- flist.f
+incdir+common
common/rat_pkg.sv
rat/checkpoint_ram.sv
rat/rat_map.sv
logic/checkpoint_ctrl.sv
logic/rename_top.sv
sim/rename_checker.sv
sim/rename_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the rename testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module rename_tb -o rename_sim
./obj_dir/rename_sim +verilator+error+limit+100 > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1

//--- sim/rename_tb.sv
// Directed testbench for the rename alias table
// Reference map model, LFSR stimulus, per-cycle checks, timeout and report
`timescale 1ns/1ps
`include "rat_config.svh"

module rename_tb;
	import rat_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int NCP      = `RAT_NCP;
	localparam int AREGS    = `RAT_AREGS;
	localparam int NREAD    = `RAT_NREAD;
	// Tests take roughly 130 cycles including reset, limit leaves wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst;
	logic enq;
	logic br_q;
	logic commit_br;
	logic restore;
	cp_idx_t miss_cp;
	logic [`RAT_PREGS-1:0] avail;
	logic [`RAT_PREGS-1:0] reclaim;
	logic wr0;
	logic wr1;
	logic cmt0;
	logic cmt1;
	areg_t wr_a0;
	areg_t wr_a1;
	areg_t cmt_a0;
	areg_t cmt_a1;
	preg_t wr_p0;
	preg_t wr_p1;
	preg_t cmt_p0;
	preg_t cmt_p1;
	areg_t src [NREAD];
	preg_t src_p [NREAD];
	logic free_v0;
	logic free_v1;
	preg_t free_0;
	preg_t free_1;
	logic stall;
	cp_idx_t cur_cp;

	// Reference model state, one map per checkpoint
	preg_t ref_map [NCP][AREGS];
	cp_idx_t ref_cur;
	cp_idx_t ref_old;
	logic exp_fv [2];
	preg_t exp_f [2];

	int errors = 0;
	int cycles = 0;
	logic [31:0] lfsr = 32'd32725;

	rename_top u_rename_top (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	// Taps 32,22,2,1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic areg_t rand_areg();
		return areg_t'(rand_bits($bits(areg_t)));
	endfunction

	function automatic preg_t rand_preg();
		return preg_t'(rand_bits($bits(preg_t)));
	endfunction

	task automatic drive_idle();
		enq = 1'b0;
		br_q = 1'b0;
		commit_br = 1'b0;
		restore = 1'b0;
		miss_cp = '0;
		avail = '0;
		wr0 = 1'b0;
		wr1 = 1'b0;
		cmt0 = 1'b0;
		cmt1 = 1'b0;
		wr_a0 = '0;
		wr_a1 = '0;
		wr_p0 = '0;
		wr_p1 = '0;
		cmt_a0 = '0;
		cmt_a1 = '0;
		cmt_p0 = '0;
		cmt_p1 = '0;
		for (int r = 0; r < NREAD; r++) begin
			src[r] = '0;
		end
	endtask

	// Two random renames in one enqueued group
	task automatic drive_renames();
		enq = 1'b1;
		wr0 = 1'b1;
		wr1 = 1'b1;
		wr_a0 = rand_areg();
		wr_a1 = rand_areg();
		wr_p0 = rand_preg();
		wr_p1 = rand_preg();
	endtask

	// ========================================
	// Reference model and checks
	// ========================================

	// Stored map of the current checkpoint with same-cycle rename bypass
	function automatic preg_t ref_lookup(input areg_t a);
		preg_t p;
		p = ref_map[ref_cur][a];
		if (enq && wr0 && a == wr_a0) begin
			p = wr_p0;
		end
		if (enq && wr1 && a == wr_a1) begin
			p = wr_p1;
		end
		return p;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			errors++;
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// One clock: check combinational outputs, advance the model, check registered outputs
	task automatic tick(input string name);
		preg_t nxt [AREGS];
		logic full;
		logic take;
		#5;
		full = ((ref_cur - ref_old) == cp_idx_t'(NCP - 1));
		take = br_q && !full && !restore;
		check({name, " stall"}, 64'(br_q && full), 64'(stall));
		check({name, " reclaim"}, restore ? avail : '0, reclaim);
		for (int r = 0; r < NREAD; r++) begin
			check($sformatf("%s src_p[%0d]", name, r), 64'(ref_lookup(src[r])), 64'(src_p[r]));
		end
		exp_fv[0] = cmt0;
		exp_fv[1] = cmt1;
		exp_f[0] = ref_map[ref_cur][cmt_a0];
		exp_f[1] = ref_map[ref_cur][cmt_a1];
		for (int a = 0; a < AREGS; a++) begin
			nxt[a] = ref_map[ref_cur][a];
		end
		// Commits first, renames after, later slot wins
		if (cmt0) nxt[cmt_a0] = cmt_p0;
		if (cmt1) nxt[cmt_a1] = cmt_p1;
		if (enq && wr0) nxt[wr_a0] = wr_p0;
		if (enq && wr1) nxt[wr_a1] = wr_p1;
		for (int a = 0; a < AREGS; a++) begin
			ref_map[ref_cur][a] = nxt[a];
			if (take) begin
				ref_map[ref_cur + 1'b1][a] = nxt[a];
			end
		end
		if (restore) begin
			ref_cur = miss_cp;
		end else if (take) begin
			ref_cur = ref_cur + 1'b1;
		end
		if (commit_br) begin
			ref_old = ref_old + 1'b1;
		end
		@(negedge clk);
		check({name, " free_v0"}, 64'(exp_fv[0]), 64'(free_v0));
		check({name, " free_v1"}, 64'(exp_fv[1]), 64'(free_v1));
		if (exp_fv[0]) check({name, " free_0"}, 64'(exp_f[0]), 64'(free_0));
		if (exp_fv[1]) check({name, " free_1"}, 64'(exp_f[1]), 64'(free_1));
		check({name, " cur_cp"}, 64'(ref_cur), 64'(cur_cp));
	endtask

	// Walk every architectural register through the lookup ports
	task automatic check_map(input string name);
		drive_idle();
		for (int g = 0; g < AREGS; g += NREAD) begin
			for (int r = 0; r < NREAD; r++) begin
				src[r] = areg_t'(g + r);
			end
			tick(name);
		end
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic reset_map();
		check("reset_map cur_cp", 64'(0), 64'(cur_cp));
		// Strobes straight out of reset, before any commit
		check("reset_map stall", 64'(0), 64'(stall));
		check("reset_map free_v0", 64'(0), 64'(free_v0));
		check("reset_map free_v1", 64'(0), 64'(free_v1));
		check_map("reset_map");
	endtask

	task automatic rename_bypass();
		for (int i = 0; i < 12; i++) begin
			drive_renames();
			// Odd rounds put both slots on one register
			if (i % 2 == 1) wr_a1 = wr_a0;
			src[0] = wr_a0;
			src[1] = wr_a1;
			src[2] = rand_areg();
			src[3] = rand_areg();
			tick("rename_bypass");
			enq = 1'b0;
			wr0 = 1'b0;
			wr1 = 1'b0;
			tick("rename_bypass");
		end
		// Renames without enq are ignored
		drive_renames();
		enq = 1'b0;
		src[0] = wr_a0;
		src[1] = wr_a1;
		tick("rename_bypass");
		check_map("rename_bypass");
	endtask

	task automatic commit_free();
		for (int i = 0; i < 8; i++) begin
			drive_idle();
			cmt0 = 1'b1;
			cmt1 = 1'b1;
			cmt_a0 = rand_areg();
			cmt_a1 = rand_areg();
			cmt_p0 = rand_preg();
			cmt_p1 = rand_preg();
			// Rename on the committed register in odd rounds
			if (i % 2 == 1) begin
				drive_renames();
				wr_a0 = cmt_a0;
			end
			src[0] = cmt_a0;
			src[1] = cmt_a1;
			tick("commit_free");
			cmt0 = 1'b0;
			cmt1 = 1'b0;
			enq = 1'b0;
			tick("commit_free");
		end
		check_map("commit_free");
	endtask

	task automatic checkpoint_restore();
		cp_idx_t saved;
		saved = ref_cur;
		drive_renames();
		br_q = 1'b1;
		tick("checkpoint_restore");
		br_q = 1'b0;
		for (int i = 0; i < 3; i++) begin
			drive_renames();
			tick("checkpoint_restore");
		end
		drive_idle();
		restore = 1'b1;
		miss_cp = saved;
		avail = {rand_bits(32), rand_bits(32)};
		// Branch in the restore cycle loses
		br_q = 1'b1;
		tick("checkpoint_restore");
		check("checkpoint_restore cur_cp", 64'(saved), 64'(cur_cp));
		check_map("checkpoint_restore");
	endtask

	task automatic stall_limit();
		for (int i = 0; i < NCP - 1; i++) begin
			drive_renames();
			br_q = 1'b1;
			tick("stall_limit");
		end
		drive_idle();
		br_q = 1'b1;
		tick("stall_limit");
		br_q = 1'b0;
		commit_br = 1'b1;
		tick("stall_limit");
		commit_br = 1'b0;
		br_q = 1'b1;
		tick("stall_limit");
		check_map("stall_limit");
	endtask

	initial begin
		int total;
		drive_idle();
		rst = 1'b1;
		ref_cur = '0;
		ref_old = '0;
		exp_fv[0] = 1'b0;
		exp_fv[1] = 1'b0;
		for (int c = 0; c < NCP; c++) begin
			for (int a = 0; a < AREGS; a++) begin
				ref_map[c][a] = preg_t'(a);
			end
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_map();
		rename_bypass();
		commit_free();
		checkpoint_restore();
		stall_limit();
		total = errors + u_rename_top.u_rename_checker.err_cnt;
		$display("Errors: %0d testbench, %0d assertion", errors,
			u_rename_top.u_rename_checker.err_cnt);
		if (total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- sim/rename_checker.sv
// Bound port assertions for the rename top level
`timescale 1ns/1ps
`include "rat_config.svh"

module rename_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  br_q,
	input logic                  restore,
	input logic                  stall,
	input logic [`RAT_PREGS-1:0] reclaim,
	input logic                  free_v0,
	input logic                  free_v1
);
	// Failed assertions so far, read by the testbench report
	int err_cnt = 0;

	// Stall only answers a queued branch
	stall_needs_branch: assert property (@(posedge clk) disable iff (rst) !br_q |-> !stall)
		else begin
			err_cnt++;
			$error("stall raised without a queued branch");
		end

	// Nothing is reclaimed outside a restore
	reclaim_needs_restore: assert property (@(posedge clk) disable iff (rst)
		!restore |-> (reclaim == '0))
		else begin
			err_cnt++;
			$error("reclaim nonzero while restore is low");
		end

	// Freed-register strobes come out of reset low
	free_low_after_reset: assert property (@(posedge clk) rst |=> (!free_v0 && !free_v1))
		else begin
			err_cnt++;
			$error("free valid high in the cycle after reset");
		end

endmodule

bind rename_top rename_checker u_rename_checker (.*);

//--- logic/rename_top.sv
// Rename stage alias table top level
// Checkpoint controller and rename map
`timescale 1ns/1ps
`include "rat_config.svh"

module rename_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enq,
	input  logic                  br_q,
	input  logic                  commit_br,
	input  logic                  restore,
	input  rat_pkg::cp_idx_t      miss_cp,
	input  logic [`RAT_PREGS-1:0] avail,
	input  logic                  wr0,
	input  logic                  wr1,
	input  rat_pkg::areg_t        wr_a0,
	input  rat_pkg::areg_t        wr_a1,
	input  rat_pkg::preg_t        wr_p0,
	input  rat_pkg::preg_t        wr_p1,
	input  logic                  cmt0,
	input  logic                  cmt1,
	input  rat_pkg::areg_t        cmt_a0,
	input  rat_pkg::areg_t        cmt_a1,
	input  rat_pkg::preg_t        cmt_p0,
	input  rat_pkg::preg_t        cmt_p1,
	input  rat_pkg::areg_t        src [`RAT_NREAD],
	output rat_pkg::preg_t        src_p [`RAT_NREAD],
	output logic                  free_v0,
	output logic                  free_v1,
	output rat_pkg::preg_t        free_0,
	output rat_pkg::preg_t        free_1,
	output logic                  stall,
	output logic [`RAT_PREGS-1:0] reclaim,
	output rat_pkg::cp_idx_t      cur_cp
);

	// New checkpoint pulse from controller to map
	logic take_cp;

	checkpoint_ctrl u_checkpoint_ctrl (
		.clk       (clk),
		.rst       (rst),
		.br_q      (br_q),
		.commit_br (commit_br),
		.restore   (restore),
		.miss_cp   (miss_cp),
		.avail     (avail),
		.cur_cp    (cur_cp),
		.take_cp   (take_cp),
		.stall     (stall),
		.reclaim   (reclaim)
	);

	rat_map u_rat_map (
		.clk     (clk),
		.rst     (rst),
		.cur_cp  (cur_cp),
		.take_cp (take_cp),
		.enq     (enq),
		.wr0     (wr0),
		.wr1     (wr1),
		.wr_a0   (wr_a0),
		.wr_a1   (wr_a1),
		.wr_p0   (wr_p0),
		.wr_p1   (wr_p1),
		.cmt0    (cmt0),
		.cmt1    (cmt1),
		.cmt_a0  (cmt_a0),
		.cmt_a1  (cmt_a1),
		.cmt_p0  (cmt_p0),
		.cmt_p1  (cmt_p1),
		.src     (src),
		.src_p   (src_p),
		.free_v0 (free_v0),
		.free_v1 (free_v1),
		.free_0  (free_0),
		.free_1  (free_1)
	);

endmodule

//--- logic/checkpoint_ctrl.sv
// Checkpoint controller: current and oldest index, branch stall, restore
`timescale 1ns/1ps
`include "rat_config.svh"

module checkpoint_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  br_q,
	input  logic                  commit_br,
	input  logic                  restore,
	input  rat_pkg::cp_idx_t      miss_cp,
	input  logic [`RAT_PREGS-1:0] avail,
	output rat_pkg::cp_idx_t      cur_cp,
	output logic                  take_cp,
	output logic                  stall,
	output logic [`RAT_PREGS-1:0] reclaim
);
	import rat_pkg::*;

	// Oldest checkpoint still held by an unresolved branch
	cp_idx_t oldest_cp;
	// Outstanding branches
	cp_idx_t out_cnt;
	logic    cp_full;

	// Index difference works modulo the checkpoint count
	assign out_cnt = cur_cp - oldest_cp;
	assign cp_full = (out_cnt == cp_idx_t'(`RAT_NCP - 1));

	// No free checkpoint, hold the branch off
	assign stall   = br_q & cp_full;

	// Accepted branch, restore takes priority
	assign take_cp = br_q & ~cp_full & ~restore;

	// ========================================
	// Index registers
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			cur_cp    <= '0;
			oldest_cp <= '0;
		end else begin
			if (restore) begin
				cur_cp <= miss_cp;
			end else if (take_cp) begin
				cur_cp <= cur_cp + 1'b1;
			end
			// Branch retired, its checkpoint is released
			if (commit_br) begin
				oldest_cp <= oldest_cp + 1'b1;
			end
		end
	end

	// Registers allocated past the missed branch go back
	assign reclaim = restore ? avail : '0;

endmodule

//--- rat/rat_map.sv
// Rename map datapath: bypassed source lookup, write merge, freed registers
// Owns the checkpoint map storage
`timescale 1ns/1ps
`include "rat_config.svh"

module rat_map (
	input  logic             clk,
	input  logic             rst,
	input  rat_pkg::cp_idx_t cur_cp,
	input  logic             take_cp,
	input  logic             enq,
	input  logic             wr0,
	input  logic             wr1,
	input  rat_pkg::areg_t   wr_a0,
	input  rat_pkg::areg_t   wr_a1,
	input  rat_pkg::preg_t   wr_p0,
	input  rat_pkg::preg_t   wr_p1,
	input  logic             cmt0,
	input  logic             cmt1,
	input  rat_pkg::areg_t   cmt_a0,
	input  rat_pkg::areg_t   cmt_a1,
	input  rat_pkg::preg_t   cmt_p0,
	input  rat_pkg::preg_t   cmt_p1,
	input  rat_pkg::areg_t   src [`RAT_NREAD],
	output rat_pkg::preg_t   src_p [`RAT_NREAD],
	output logic             free_v0,
	output logic             free_v1,
	output rat_pkg::preg_t   free_0,
	output rat_pkg::preg_t   free_1
);
	import rat_pkg::*;

	// Map of the current checkpoint, as stored
	preg_t cur_map [`RAT_AREGS];
	// Map after this cycle's writes
	preg_t nxt_map [`RAT_AREGS];
	logic [`RAT_AREGS-1:0] we_mask;

	// Write slots in priority order, later index wins
	// 0,1 are commits, 2,3 are renames
	logic  upd_v [4];
	areg_t upd_a [4];
	preg_t upd_p [4];

	// Commit slot registers looked up for freeing
	areg_t cmt_a [2];
	preg_t free_p [2];
	logic [1:0] free_vq;

	assign upd_v[0] = cmt0;
	assign upd_v[1] = cmt1;
	assign upd_v[2] = enq & wr0;
	assign upd_v[3] = enq & wr1;
	assign upd_a[0] = cmt_a0;
	assign upd_a[1] = cmt_a1;
	assign upd_a[2] = wr_a0;
	assign upd_a[3] = wr_a1;
	assign upd_p[0] = cmt_p0;
	assign upd_p[1] = cmt_p1;
	assign upd_p[2] = wr_p0;
	assign upd_p[3] = wr_p1;

	assign cmt_a[0] = cmt_a0;
	assign cmt_a[1] = cmt_a1;

	checkpoint_ram u_checkpoint_ram (
		.clk     (clk),
		.rst     (rst),
		.rd_cp   (cur_cp),
		.rd_map  (cur_map),
		.we_mask (we_mask),
		.wr_map  (nxt_map),
		.copy    (take_cp)
	);

	// ========================================
	// Write merge
	// ========================================
	always_comb begin
		for (int a = 0; a < `RAT_AREGS; a++) begin
			nxt_map[a] = cur_map[a];
			we_mask[a] = 1'b0;
		end
		// Walk slots in order so the last writer of a register wins
		for (int s = 0; s < 4; s++) begin
			if (upd_v[s]) begin
				nxt_map[upd_a[s]] = upd_p[s];
				we_mask[upd_a[s]] = 1'b1;
			end
		end
	end

	// ========================================
	// Source lookup
	// ========================================
	always_comb begin
		for (int r = 0; r < `RAT_NREAD; r++) begin
			src_p[r] = cur_map[src[r]];
			// Same-cycle renames bypass the stored map, slot 1 last
			if (upd_v[2] && src[r] == wr_a0) begin
				src_p[r] = wr_p0;
			end
			if (upd_v[3] && src[r] == wr_a1) begin
				src_p[r] = wr_p1;
			end
		end
	end

	// Mapping replaced by each commit, taken before this edge's writes
	always_ff @(posedge clk) begin
		for (int s = 0; s < 2; s++) begin
			free_p[s] <= cur_map[cmt_a[s]];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			free_vq <= 2'b00;
		end else begin
			free_vq <= {cmt1, cmt0};
		end
	end

	assign free_v0 = free_vq[0];
	assign free_v1 = free_vq[1];
	assign free_0  = free_p[0];
	assign free_1  = free_p[1];

endmodule

//--- rat/checkpoint_ram.sv
// Checkpoint map storage, one map per checkpoint
`timescale 1ns/1ps
`include "rat_config.svh"

module checkpoint_ram (
	input  logic              clk,
	input  logic              rst,
	input  rat_pkg::cp_idx_t  rd_cp,
	output rat_pkg::preg_t    rd_map [`RAT_AREGS],
	input  logic [`RAT_AREGS-1:0] we_mask,
	input  rat_pkg::preg_t    wr_map [`RAT_AREGS],
	input  logic              copy
);
	import rat_pkg::*;

	// Storage, indexed by checkpoint then architectural register
	preg_t   mem [`RAT_NCP][`RAT_AREGS];

	// Checkpoint that receives the copy
	cp_idx_t nxt_cp;

	assign nxt_cp = rd_cp + 1'b1;

	// Asynchronous read of the current map
	always_comb begin
		for (int a = 0; a < `RAT_AREGS; a++) begin
			rd_map[a] = mem[rd_cp][a];
		end
	end

	// ========================================
	// Write port
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			// Identity map in every checkpoint
			for (int c = 0; c < `RAT_NCP; c++) begin
				for (int a = 0; a < `RAT_AREGS; a++) begin
					mem[c][a] <= preg_t'(a);
				end
			end
		end else begin
			for (int a = 0; a < `RAT_AREGS; a++) begin
				// Per-entry update of the live map
				if (we_mask[a]) begin
					mem[rd_cp][a] <= wr_map[a];
				end
				// Whole merged map goes to the new checkpoint
				if (copy) begin
					mem[nxt_cp][a] <= wr_map[a];
				end
			end
		end
	end

endmodule

//--- common/rat_pkg.sv
// Register alias table types
// Register numbers and checkpoint index
`include "rat_config.svh"

package rat_pkg;

	// Architectural register number
	typedef logic [$clog2(`RAT_AREGS)-1:0] areg_t;

	// Physical register number
	typedef logic [$clog2(`RAT_PREGS)-1:0] preg_t;

	// Checkpoint index, wraps modulo the checkpoint count
	typedef logic [$clog2(`RAT_NCP)-1:0] cp_idx_t;

endpackage

//--- common/rat_config.svh
// Sizing defines for the register alias table
// Register counts, checkpoint count and lookup port count
`ifndef RAT_CONFIG_SVH
`define RAT_CONFIG_SVH

// ========================================
// Register file sizes
// ========================================

// Architectural registers seen by the ISA
`define RAT_AREGS 32

// Physical registers behind the rename map
`define RAT_PREGS 64

// ========================================
// Checkpoints and ports
// ========================================

// One full map per outstanding branch, power of two
`define RAT_NCP 16

// Source lookup ports per cycle
`define RAT_NREAD 4

`endif
